//--- Makefile
TOP = tb_top

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir

//--- flist.f
hw/psram_pkg.sv
hw/psram_clk_gen.sv
hw/psram_cfg_seq.sv
hw/psram_access.sv
hw/psram_bus_arbiter.sv
hw/psram_top.sv
testbench/tb_clk.sv
testbench/psram_model.sv
testbench/tb_top.sv

//--- hw/psram_access.sv
`timescale 1ns/1ps

module psram_access #(
    parameter int CPH_CYCLES = 6,
    parameter int LATENCY    = 5,
    parameter int BURST_LEN  = 16
) (
    input  logic              sys_clk,
    input  logic              sys_rst,
    input  logic              psram_exe,
    input  logic              rw_ctrl,
    input  psram_pkg::addr_t  addr_in,
    input  psram_pkg::data_t  wr_data,
    input  psram_pkg::mask_t  wr_mask,
    input  logic              beat,
    input  logic              period_end,
    input  logic              bus_gnt,
    input  psram_pkg::data_t  dq_in,
    input  psram_pkg::mask_t  dm_in,
    output logic              bus_req,
    output psram_pkg::data_t  dq_out,
    output psram_pkg::mask_t  dm_out,
    output logic              dq_oe,
    output logic              ce,
    output logic              clk_run,
    output logic              wr_req,
    output psram_pkg::data_t  rd_data,
    output logic              rd_valid,
    output logic              done
);

    import psram_pkg::*;

    acc_state_e state;
    acc_state_e next_state;
    beat_cnt_t  phase_cnt;
    beat_cnt_t  beat_cnt;
    logic       phase_done;
    addr_t      addr_reg;
    logic       is_write;
    logic       dm_d0;
    logic       dm_edge;

    assign clk_run = (state == ACC_COMMAND) || (state == ACC_ADDRESS)
                     || (state == ACC_LATENCY) || (state == ACC_WRITE_DATA)
                     || (state == ACC_READ_DATA);
    assign ce      = !(clk_run || state == ACC_FINISH);
    assign bus_req = (state != ACC_IDLE);
    assign wr_req  = (state == ACC_WRITE_DATA) && beat;
    assign done    = (state == ACC_CPH_WAIT) && phase_done;
    assign dm_edge = (state == ACC_READ_DATA) && (dm_in[0] != dm_d0)
                     && (beat_cnt != beat_cnt_t'(BURST_LEN));

    // lags the state by a cycle so the last address byte holds through its falling edge
    // for a read the memory owns dq from the latency phase on
    always_ff @(posedge sys_clk) begin
        if (!sys_rst) begin
            dq_oe <= 1'b0;
        end else begin
            dq_oe <= (state == ACC_COMMAND) || (state == ACC_ADDRESS)
                     || (is_write && (state == ACC_LATENCY || state == ACC_WRITE_DATA));
        end
    end

    always_comb begin
        phase_done = 1'b0;
        next_state = state;
        case (state)
            ACC_IDLE: begin
                phase_done = psram_exe;
                next_state = ACC_WAIT_GRANT;
            end
            ACC_WAIT_GRANT: begin
                phase_done = bus_gnt;
                next_state = ACC_COMMAND;
            end
            ACC_COMMAND: begin
                phase_done = period_end;
                next_state = ACC_ADDRESS;
            end
            ACC_ADDRESS: begin
                phase_done = period_end && (phase_cnt == beat_cnt_t'(1));
                next_state = ACC_LATENCY;
            end
            ACC_LATENCY: begin
                phase_done = period_end && (phase_cnt == beat_cnt_t'(LATENCY - 1));
                next_state = is_write ? ACC_WRITE_DATA : ACC_READ_DATA;
            end
            ACC_WRITE_DATA: begin
                phase_done = period_end && (phase_cnt == beat_cnt_t'(BURST_LEN / 2 - 1));
                next_state = ACC_FINISH;
            end
            ACC_READ_DATA: begin
                phase_done = (beat_cnt == beat_cnt_t'(BURST_LEN));
                next_state = ACC_FINISH;
            end
            ACC_FINISH: begin
                phase_done = 1'b1;
                next_state = ACC_CPH_WAIT;
            end
            default: begin
                phase_done = (phase_cnt == beat_cnt_t'(CPH_CYCLES - 1));
                next_state = ACC_IDLE;
            end
        endcase
    end

    // memory clocks while clocked, sys_clk cycles during cph_wait
    always_ff @(posedge sys_clk) begin
        if (!sys_rst) begin
            state     <= ACC_IDLE;
            phase_cnt <= '0;
        end else if (phase_done) begin
            state     <= next_state;
            phase_cnt <= '0;
        end else if ((clk_run && period_end) || state == ACC_CPH_WAIT) begin
            phase_cnt <= phase_cnt + 1'b1;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (state == ACC_IDLE && psram_exe) begin
            addr_reg <= addr_in;
            is_write <= rw_ctrl;
        end
    end

    // address bytes and read strobe edges
    always_ff @(posedge sys_clk) begin
        if (!sys_rst) begin
            beat_cnt <= '0;
        end else if (state == ACC_ADDRESS && beat) begin
            beat_cnt <= beat_cnt + 1'b1;
        end else if (dm_edge) begin
            beat_cnt <= beat_cnt + 1'b1;
        end else if (state == ACC_COMMAND || state == ACC_LATENCY) begin
            beat_cnt <= '0;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (state == ACC_IDLE) begin
            dq_out <= '0;
            dm_out <= '0;
        end else if (beat) begin
            dm_out <= '0;
            case (state)
                ACC_COMMAND:
                    dq_out <= {8'h00, is_write ? CMD_LINEAR_WRITE : CMD_LINEAR_READ};
                ACC_ADDRESS:
                    dq_out <= {8'h00, addr_reg[31 - 8 * beat_cnt[1:0] -: 8]};
                ACC_WRITE_DATA: begin
                    dq_out <= wr_data;
                    dm_out <= wr_mask;
                end
                default: dq_out <= '0;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!sys_rst) begin
            dm_d0    <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            dm_d0    <= dm_in[0];
            rd_valid <= dm_edge;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (dm_edge) begin
            rd_data <= dq_in;
        end
    end

endmodule

//--- hw/psram_bus_arbiter.sv
`timescale 1ns/1ps

module psram_bus_arbiter (
    input  logic              sys_clk,
    input  logic              sys_rst,
    input  logic              cfg_bus_req,
    input  psram_pkg::data_t  cfg_dq_out,
    input  psram_pkg::mask_t  cfg_dm_out,
    input  logic              cfg_dq_oe,
    input  logic              cfg_ce,
    input  logic              cfg_clk_run,
    input  logic              acc_bus_req,
    input  psram_pkg::data_t  acc_dq_out,
    input  psram_pkg::mask_t  acc_dm_out,
    input  logic              acc_dq_oe,
    input  logic              acc_ce,
    input  logic              acc_clk_run,
    output logic              cfg_gnt,
    output logic              acc_gnt,
    output logic              clk_run,
    output logic              psram_ce,
    inout  wire  psram_pkg::data_t psram_dq,
    inout  wire  psram_pkg::mask_t psram_dm,
    output psram_pkg::data_t  dq_in,
    output psram_pkg::mask_t  dm_in
);

    import psram_pkg::*;

    data_t dq_sel;
    mask_t dm_sel;
    logic  oe_sel;

    // configuration wins a tie, a grant holds until its request drops
    always_ff @(posedge sys_clk) begin
        if (!sys_rst) begin
            cfg_gnt <= 1'b0;
            acc_gnt <= 1'b0;
        end else if (!cfg_gnt && !acc_gnt) begin
            cfg_gnt <= cfg_bus_req;
            acc_gnt <= !cfg_bus_req && acc_bus_req;
        end else begin
            cfg_gnt <= cfg_gnt && cfg_bus_req;
            acc_gnt <= acc_gnt && acc_bus_req;
        end
    end

    always_comb begin
        dq_sel   = '0;
        dm_sel   = '0;
        oe_sel   = 1'b0;
        psram_ce = 1'b1;
        clk_run  = 1'b0;
        if (cfg_gnt) begin
            dq_sel   = cfg_dq_out;
            dm_sel   = cfg_dm_out;
            oe_sel   = cfg_dq_oe;
            psram_ce = cfg_ce;
            clk_run  = cfg_clk_run;
        end else if (acc_gnt) begin
            dq_sel   = acc_dq_out;
            dm_sel   = acc_dm_out;
            oe_sel   = acc_dq_oe;
            psram_ce = acc_ce;
            clk_run  = acc_clk_run;
        end
    end

    assign psram_dq = oe_sel ? dq_sel : 'z;
    assign psram_dm = oe_sel ? dm_sel : 'z;
    assign dq_in    = psram_dq;
    assign dm_in    = psram_dm;

endmodule

//--- hw/psram_cfg_seq.sv
`timescale 1ns/1ps

module psram_cfg_seq #(
    parameter int INIT_CYCLES = 40000,
    parameter int CPH_CYCLES  = 6,
    parameter int LATENCY     = 5,
    parameter int BURST_LEN   = 16
) (
    input  logic              sys_clk,
    input  logic              sys_rst,
    input  logic              beat,
    input  logic              period_end,
    input  logic              bus_gnt,
    output logic              bus_req,
    output psram_pkg::data_t  dq_out,
    output logic              dq_oe,
    output logic              ce,
    output logic              clk_run,
    output logic              ready
);

    import psram_pkg::*;

    localparam int CNT_W = $clog2(INIT_CYCLES + CPH_CYCLES + 4);
    localparam logic [2:0] LAT_CODE = latency_code(LATENCY);
    localparam logic [1:0] BL_CODE  = burst_code(BURST_LEN);

    cfg_state_e       state;
    logic [CNT_W-1:0] wait_cnt;
    logic [1:0]       reg_cnt;
    logic [1:0]       beat_idx;
    logic             tick;
    logic             wait_done;
    logic             active;
    logic [7:0]       mr_addr;
    logic [7:0]       mr_value;

    assign active  = (state == CFG_GLOBAL_RESET) || (state == CFG_RESET_HOLD)
                     || (state == CFG_REG_WRITE);
    assign clk_run = active;
    assign bus_req = (state != CFG_READY);
    assign ready   = (state == CFG_READY);

    // power wait counts only once the bus is ours
    always_comb begin
        tick      = period_end;
        wait_done = 1'b0;
        case (state)
            CFG_POWER_WAIT: begin
                tick      = bus_gnt;
                wait_done = (wait_cnt == CNT_W'(INIT_CYCLES - 1));
            end
            CFG_GLOBAL_RESET: wait_done = period_end;
            CFG_RESET_HOLD:   wait_done = period_end && (wait_cnt == CNT_W'(2));
            CFG_REG_WRITE:    wait_done = period_end && (wait_cnt == CNT_W'(1));
            CFG_CPH_WAIT: begin
                tick      = 1'b1;
                wait_done = (wait_cnt == CNT_W'(CPH_CYCLES - 1));
            end
            default: tick = 1'b0;
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (!sys_rst) begin
            state    <= CFG_POWER_WAIT;
            wait_cnt <= '0;
            reg_cnt  <= '0;
        end else if (wait_done) begin
            wait_cnt <= '0;
            case (state)
                CFG_POWER_WAIT:   state <= CFG_GLOBAL_RESET;
                CFG_GLOBAL_RESET: state <= CFG_RESET_HOLD;
                CFG_RESET_HOLD:   state <= CFG_CPH_WAIT;
                CFG_REG_WRITE: begin
                    state   <= CFG_CPH_WAIT;
                    reg_cnt <= reg_cnt + 1'b1;
                end
                default: state <= (reg_cnt == 2'd3) ? CFG_READY : CFG_REG_WRITE;
            endcase
        end else if (tick) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // MR0, MR4, MR8 in turn
    always_comb begin
        case (reg_cnt)
            2'd0: begin
                mr_addr  = MR0_ADDR;
                mr_value = {3'b000, LAT_CODE, 2'b01};
            end
            2'd1: begin
                mr_addr  = MR4_ADDR;
                mr_value = {LAT_CODE, 5'b00000};
            end
            default: begin
                mr_addr  = MR8_ADDR;
                mr_value = {2'b01, 4'b0000, BL_CODE};
            end
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (!sys_rst || state != CFG_REG_WRITE) begin
            beat_idx <= '0;
        end else if (beat) begin
            beat_idx <= beat_idx + 1'b1;
        end
    end

    // one byte per beat on the low lane
    always_ff @(posedge sys_clk) begin
        if (state == CFG_POWER_WAIT) begin
            dq_out <= '0;
        end else if (beat) begin
            case (state)
                CFG_GLOBAL_RESET: dq_out <= {8'h00, CMD_GLOBAL_RESET};
                CFG_REG_WRITE: begin
                    case (beat_idx)
                        2'd0:    dq_out <= {8'h00, CMD_REG_WRITE};
                        2'd1:    dq_out <= '0;
                        2'd2:    dq_out <= {8'h00, mr_addr};
                        default: dq_out <= {8'h00, mr_value};
                    endcase
                end
                default: dq_out <= '0;
            endcase
        end
    end

    // ce lags the state by a cycle so the last falling edge lands inside ce low
    always_ff @(posedge sys_clk) begin
        if (!sys_rst) begin
            ce    <= 1'b1;
            dq_oe <= 1'b0;
        end else begin
            ce    <= !active;
            dq_oe <= active;
        end
    end

endmodule

//--- hw/psram_clk_gen.sv
`timescale 1ns/1ps

module psram_clk_gen #(
    parameter int CLK_DIV = 4
) (
    input  logic sys_clk,
    input  logic sys_rst,
    input  logic clk_run,
    output logic psram_clk,
    output logic beat,
    output logic period_end
);

    localparam int CNT_W = $clog2(CLK_DIV);

    logic [CNT_W-1:0] cnt;

    // position inside one memory clock period
    always_ff @(posedge sys_clk) begin
        if (!sys_rst || !clk_run) begin
            cnt <= '0;
        end else if (cnt == CNT_W'(CLK_DIV - 1)) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // registered, so it follows cnt by one cycle
    // low while cnt is in the first half, high in the second
    always_ff @(posedge sys_clk) begin
        if (!sys_rst) begin
            psram_clk <= 1'b0;
        end else begin
            psram_clk <= clk_run && (cnt >= CNT_W'(CLK_DIV / 2 - 1))
                         && (cnt <= CNT_W'(CLK_DIV - 2));
        end
    end

    // data registered on a beat changes midway between clock edges
    assign beat = clk_run && ((cnt == CNT_W'(CLK_DIV / 4 - 1))
                  || (cnt == CNT_W'(3 * CLK_DIV / 4 - 1)));

    assign period_end = clk_run && (cnt == CNT_W'(CLK_DIV - 1));

endmodule

//--- hw/psram_pkg.sv
package psram_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [15:0] data_t;
    typedef logic [1:0]  mask_t;
    typedef logic [11:0] beat_cnt_t;

    typedef enum logic [2:0] {
        CFG_POWER_WAIT,
        CFG_GLOBAL_RESET,
        CFG_RESET_HOLD,
        CFG_REG_WRITE,
        CFG_CPH_WAIT,
        CFG_READY
    } cfg_state_e;

    typedef enum logic [3:0] {
        ACC_IDLE,
        ACC_WAIT_GRANT,
        ACC_COMMAND,
        ACC_ADDRESS,
        ACC_LATENCY,
        ACC_WRITE_DATA,
        ACC_READ_DATA,
        ACC_FINISH,
        ACC_CPH_WAIT
    } acc_state_e;

    // command bytes
    localparam logic [7:0] CMD_GLOBAL_RESET = 8'hff;
    localparam logic [7:0] CMD_REG_WRITE    = 8'hc0;
    localparam logic [7:0] CMD_LINEAR_WRITE = 8'ha0;
    localparam logic [7:0] CMD_LINEAR_READ  = 8'h20;

    // mode register addresses
    localparam logic [7:0] MR0_ADDR = 8'h00;
    localparam logic [7:0] MR4_ADDR = 8'h04;
    localparam logic [7:0] MR8_ADDR = 8'h08;

    function automatic logic [2:0] latency_code(input int latency);
        case (latency)
            3:       return 3'd0;
            4:       return 3'd1;
            5:       return 3'd2;
            6:       return 3'd3;
            7:       return 3'd4;
            default: return 3'd2;
        endcase
    endfunction

    function automatic logic [1:0] burst_code(input int burst_len);
        case (burst_len)
            32:      return 2'd1;
            64:      return 2'd2;
            default: return 2'd0;
        endcase
    endfunction

endpackage

//--- hw/psram_top.sv
`timescale 1ns/1ps

module psram_top #(
    parameter int CLK_DIV     = 4,
    parameter int INIT_CYCLES = 40000,
    parameter int CPH_CYCLES  = 6,
    parameter int LATENCY     = 5,
    parameter int BURST_LEN   = 16
) (
    input  logic              sys_clk,
    input  logic              sys_rst,
    input  logic              psram_exe,
    input  logic              rw_ctrl,
    input  psram_pkg::addr_t  addr_in,
    input  psram_pkg::data_t  wr_data,
    input  psram_pkg::mask_t  wr_mask,
    output logic              ready,
    output logic              wr_req,
    output psram_pkg::data_t  rd_data,
    output logic              rd_valid,
    output logic              done,
    output logic              psram_clk,
    output logic              psram_ce,
    inout  wire  psram_pkg::data_t psram_dq,
    inout  wire  psram_pkg::mask_t psram_dm
);

    import psram_pkg::*;

    logic  beat;
    logic  period_end;
    logic  clk_run;
    data_t dq_in;
    mask_t dm_in;

    // configuration side
    logic  cfg_bus_req;
    logic  cfg_gnt;
    data_t cfg_dq_out;
    logic  cfg_dq_oe;
    logic  cfg_ce;
    logic  cfg_clk_run;

    // access side
    logic  acc_bus_req;
    logic  acc_gnt;
    data_t acc_dq_out;
    mask_t acc_dm_out;
    logic  acc_dq_oe;
    logic  acc_ce;
    logic  acc_clk_run;

    psram_clk_gen #(
        .CLK_DIV (CLK_DIV)
    ) u_clk_gen (
        .sys_clk    (sys_clk),
        .sys_rst    (sys_rst),
        .clk_run    (clk_run),
        .psram_clk  (psram_clk),
        .beat       (beat),
        .period_end (period_end)
    );

    psram_cfg_seq #(
        .INIT_CYCLES (INIT_CYCLES),
        .CPH_CYCLES  (CPH_CYCLES),
        .LATENCY     (LATENCY),
        .BURST_LEN   (BURST_LEN)
    ) u_cfg_seq (
        .sys_clk    (sys_clk),
        .sys_rst    (sys_rst),
        .beat       (beat),
        .period_end (period_end),
        .bus_gnt    (cfg_gnt),
        .bus_req    (cfg_bus_req),
        .dq_out     (cfg_dq_out),
        .dq_oe      (cfg_dq_oe),
        .ce         (cfg_ce),
        .clk_run    (cfg_clk_run),
        .ready      (ready)
    );

    psram_access #(
        .CPH_CYCLES (CPH_CYCLES),
        .LATENCY    (LATENCY),
        .BURST_LEN  (BURST_LEN)
    ) u_access (
        .sys_clk    (sys_clk),
        .sys_rst    (sys_rst),
        .psram_exe  (psram_exe),
        .rw_ctrl    (rw_ctrl),
        .addr_in    (addr_in),
        .wr_data    (wr_data),
        .wr_mask    (wr_mask),
        .beat       (beat),
        .period_end (period_end),
        .bus_gnt    (acc_gnt),
        .dq_in      (dq_in),
        .dm_in      (dm_in),
        .bus_req    (acc_bus_req),
        .dq_out     (acc_dq_out),
        .dm_out     (acc_dm_out),
        .dq_oe      (acc_dq_oe),
        .ce         (acc_ce),
        .clk_run    (acc_clk_run),
        .wr_req     (wr_req),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid),
        .done       (done)
    );

    // the sequencer never masks bytes
    psram_bus_arbiter u_arbiter (
        .sys_clk     (sys_clk),
        .sys_rst     (sys_rst),
        .cfg_bus_req (cfg_bus_req),
        .cfg_dq_out  (cfg_dq_out),
        .cfg_dm_out  ('0),
        .cfg_dq_oe   (cfg_dq_oe),
        .cfg_ce      (cfg_ce),
        .cfg_clk_run (cfg_clk_run),
        .acc_bus_req (acc_bus_req),
        .acc_dq_out  (acc_dq_out),
        .acc_dm_out  (acc_dm_out),
        .acc_dq_oe   (acc_dq_oe),
        .acc_ce      (acc_ce),
        .acc_clk_run (acc_clk_run),
        .cfg_gnt     (cfg_gnt),
        .acc_gnt     (acc_gnt),
        .clk_run     (clk_run),
        .psram_ce    (psram_ce),
        .psram_dq    (psram_dq),
        .psram_dm    (psram_dm),
        .dq_in       (dq_in),
        .dm_in       (dm_in)
    );

endmodule

//--- testbench/psram_model.sv
`timescale 1ns/1ps

module psram_model #(
    parameter int LATENCY   = 3,
    parameter int BURST_LEN = 16
) (
    input  logic       psram_clk,
    input  logic       psram_ce,
    inout  wire [15:0] psram_dq,
    inout  wire [1:0]  psram_dm
);

    // edges 0-1 command, 2-5 address, then latency
    localparam int DATA_START = 6 + 2 * LATENCY;

    logic [15:0] mem [0:255];
    logic [7:0]  cmd_log [0:15];
    logic [7:0]  reg_addr_log [0:15];
    logic [7:0]  reg_val_log [0:15];
    int          seq_cnt;
    int          edge_cnt;
    logic [7:0]  cmd;
    logic [31:0] addr;
    logic        drive_en;
    logic [15:0] drv_dq;
    logic [1:0]  drv_dm;

    assign psram_dq = drive_en ? drv_dq : 'z;
    assign psram_dm = drive_en ? drv_dm : 'z;

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 16'(i * 37) ^ 16'h5a5a;
        end
        seq_cnt  = 0;
        edge_cnt = 0;
        cmd      = 8'h00;
        addr     = '0;
        drive_en = 1'b0;
        drv_dq   = '0;
        drv_dm   = '0;
    end

    task automatic take_edge();
        logic [7:0] b;
        logic [7:0] idx;
        int         k;
        b   = psram_dq[7:0];
        k   = edge_cnt - DATA_START;
        idx = 8'(addr + 32'(k));
        if (edge_cnt == 0) begin
            cmd = b;
        end else if (cmd == 8'hc0) begin
            // C0, don't care, register address, register value
            if (edge_cnt == 2) begin
                reg_addr_log[seq_cnt] = b;
            end else if (edge_cnt == 3) begin
                reg_val_log[seq_cnt] = b;
            end
        end else if (edge_cnt >= 2 && edge_cnt <= 5) begin
            addr = {addr[23:0], b};
        end
        if (cmd == 8'ha0 && k >= 0 && k < BURST_LEN) begin
            // a set mask bit keeps the stored byte
            if (!psram_dm[0]) begin
                mem[idx][7:0] = psram_dq[7:0];
            end
            if (!psram_dm[1]) begin
                mem[idx][15:8] = psram_dq[15:8];
            end
        end
        if (cmd == 8'h20) begin
            if (edge_cnt == 6) begin
                drive_en = 1'b1;
                drv_dm   = 2'b00;
            end
            if (k >= 0 && k < BURST_LEN) begin
                drv_dq    = mem[idx];
                drv_dm[0] = !drv_dm[0];
            end
        end
        edge_cnt++;
    endtask

    // double data rate, both clock edges carry a byte or word
    always @(posedge psram_clk or negedge psram_clk) begin
        if (psram_ce === 1'b0) begin
            take_edge();
        end
    end

    always @(posedge psram_ce) begin
        if (edge_cnt > 0 && seq_cnt < 16) begin
            cmd_log[seq_cnt] = cmd;
            seq_cnt++;
        end
        edge_cnt = 0;
        drive_en = 1'b0;
    end

endmodule

//--- testbench/tb_clk.sv
`timescale 1ns/1ps

module tb_clk #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 4
) (
    output logic sys_clk,
    output logic sys_rst
);

    initial begin
        sys_clk = 1'b0;
        forever #(HALF_PERIOD) sys_clk = ~sys_clk;
    end

    // active low, released just after an edge
    initial begin
        sys_rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge sys_clk);
        #1;
        sys_rst = 1'b1;
    end

endmodule

//--- testbench/tb_top.sv
`timescale 1ns/1ps

module tb_top;

    localparam int CLK_DIV     = 4;
    localparam int INIT_CYCLES = 40;
    localparam int CPH_CYCLES  = 6;
    localparam int LATENCY     = 3;
    localparam int BURST_LEN   = 16;
    // configuration plus three bursts, with a wide margin
    localparam int TIMEOUT_CYCLES = 4000;

    logic        sys_clk;
    logic        sys_rst;
    logic        psram_exe;
    logic        rw_ctrl;
    logic [31:0] addr_in;
    logic [15:0] wr_data;
    logic [1:0]  wr_mask;
    logic        ready;
    logic        wr_req;
    logic [15:0] rd_data;
    logic        rd_valid;
    logic        done;
    logic        psram_clk;
    logic        psram_ce;
    wire  [15:0] psram_dq;
    wire  [1:0]  psram_dm;

    logic [15:0] wr_words [0:BURST_LEN-1];
    logic [1:0]  wr_masks [0:BURST_LEN-1];
    logic [15:0] rd_expect [0:BURST_LEN-1];
    int          errors   = 0;
    int          cycles   = 0;
    int          wr_cnt   = 0;
    int          rd_cnt   = 0;
    int          done_cnt = 0;
    int          requests = 0;
    logic        in_burst = 1'b0;

    tb_clk u_clk (
        .sys_clk (sys_clk),
        .sys_rst (sys_rst)
    );

    psram_top #(
        .CLK_DIV     (CLK_DIV),
        .INIT_CYCLES (INIT_CYCLES),
        .CPH_CYCLES  (CPH_CYCLES),
        .LATENCY     (LATENCY),
        .BURST_LEN   (BURST_LEN)
    ) uut (
        .sys_clk   (sys_clk),
        .sys_rst   (sys_rst),
        .psram_exe (psram_exe),
        .rw_ctrl   (rw_ctrl),
        .addr_in   (addr_in),
        .wr_data   (wr_data),
        .wr_mask   (wr_mask),
        .ready     (ready),
        .wr_req    (wr_req),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid),
        .done      (done),
        .psram_clk (psram_clk),
        .psram_ce  (psram_ce),
        .psram_dq  (psram_dq),
        .psram_dm  (psram_dm)
    );

    psram_model #(
        .LATENCY   (LATENCY),
        .BURST_LEN (BURST_LEN)
    ) u_model (
        .psram_clk (psram_clk),
        .psram_ce  (psram_ce),
        .psram_dq  (psram_dq),
        .psram_dm  (psram_dm)
    );

    // bus and handshake rules
    assert property (@(posedge sys_clk) disable iff (!sys_rst) psram_ce |-> !psram_clk)
        else begin
            errors++;
            $display("ERROR %0t: psram_clk high while psram_ce is high", $time);
        end
    assert property (@(posedge sys_clk) disable iff (!sys_rst) ready |=> ready)
        else begin
            errors++;
            $display("ERROR %0t: ready dropped after configuration", $time);
        end
    assert property (@(posedge sys_clk) disable iff (!sys_rst) !ready |-> !wr_req && !rd_valid)
        else begin
            errors++;
            $display("ERROR %0t: data strobe before ready", $time);
        end
    assert property (@(posedge sys_clk) disable iff (!sys_rst) (wr_req || rd_valid) |-> in_burst)
        else begin
            errors++;
            $display("ERROR %0t: wr_req or rd_valid outside a burst", $time);
        end
    assert property (@(posedge sys_clk) disable iff (!sys_rst) done |-> psram_ce && in_burst)
        else begin
            errors++;
            $display("ERROR %0t: done while psram_ce low or without a request", $time);
        end
    assert property (@(posedge sys_clk) disable iff (!sys_rst) done |=> !done)
        else begin
            errors++;
            $display("ERROR %0t: done longer than one cycle", $time);
        end

    task automatic check_eq(input string what, input int got, input int exp);
        assert (got == exp) else begin
            errors++;
            $display("ERROR %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // mode register values rebuilt from the register layout
    function automatic logic [7:0] mr_expect(input int idx);
        logic [2:0] lat;
        logic [1:0] bl;
        lat = (LATENCY >= 3 && LATENCY <= 7) ? 3'(LATENCY - 3) : 3'd2;
        bl  = (BURST_LEN == 64) ? 2'd2 : ((BURST_LEN == 32) ? 2'd1 : 2'd0);
        case (idx)
            0:       return {3'b000, lat, 2'b01};
            1:       return {lat, 5'b00000};
            default: return {2'b01, 4'b0000, bl};
        endcase
    endfunction

    task automatic check_config();
        check_eq("sequences before ready", u_model.seq_cnt, 4);
        check_eq("first command", u_model.cmd_log[0], 8'hff);
        for (int i = 0; i < 3; i++) begin
            check_eq("register write command", u_model.cmd_log[i + 1], 8'hc0);
            check_eq("register address", u_model.reg_addr_log[i + 1], 4 * i);
            check_eq("register value", u_model.reg_val_log[i + 1], mr_expect(i));
        end
    endtask

    task automatic start_burst(input logic write, input logic [31:0] addr);
        @(posedge sys_clk);
        #1;
        wr_cnt    = 0;
        rd_cnt    = 0;
        rw_ctrl   = write;
        addr_in   = addr;
        wr_data   = wr_words[0];
        wr_mask   = wr_masks[0];
        psram_exe = 1'b1;
        in_burst  = 1'b1;
        requests++;
        @(posedge sys_clk);
        #1;
        psram_exe = 1'b0;
    endtask

    task automatic finish_burst(input logic write);
        while (done_cnt < requests) begin
            @(posedge sys_clk);
            #1;
        end
        in_burst = 1'b0;
        check_eq("wr_req pulses", wr_cnt, write ? BURST_LEN : 0);
        check_eq("rd_valid pulses", rd_cnt, write ? 0 : BURST_LEN);
    endtask

    // next word goes out the cycle after each request
    always @(posedge sys_clk) begin
        if (wr_req) begin
            wr_cnt++;
            #1;
            if (wr_cnt < BURST_LEN) begin
                wr_data = wr_words[wr_cnt];
                wr_mask = wr_masks[wr_cnt];
            end
        end
    end

    always @(posedge sys_clk) begin
        if (rd_valid) begin
            if (rd_cnt < BURST_LEN) begin
                assert (rd_data == rd_expect[rd_cnt]) else begin
                    errors++;
                    $display("ERROR %0t: read beat %0d is %h, expected %h",
                             $time, rd_cnt, rd_data, rd_expect[rd_cnt]);
                end
            end
            rd_cnt++;
        end
        if (done) begin
            done_cnt++;
        end
    end

    always @(posedge sys_clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("errors: %0d, requests: %0d, done pulses: %0d", errors, requests, done_cnt);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        int          seed;
        logic [31:0] base;
        logic [15:0] old_word;
        seed      = 78896;
        psram_exe = 1'b0;
        rw_ctrl   = 1'b0;
        addr_in   = '0;
        wr_data   = '0;
        wr_mask   = '0;
        for (int i = 0; i < BURST_LEN; i++) begin
            wr_words[i] = 16'($random(seed));
            wr_masks[i] = 2'b00;
        end
        base = $random(seed);
        @(posedge sys_rst);
        repeat (3) @(posedge sys_clk);
        check_eq("ready during power-up", ready, 0);

        // full write, requested early and held until ready
        start_burst(1'b1, base);
        while (!ready) begin
            @(posedge sys_clk);
            #1;
        end
        check_config();
        finish_burst(1'b1);

        // second write with byte masks over the same words
        for (int i = 0; i < BURST_LEN; i++) begin
            old_word     = wr_words[i];
            wr_words[i]  = 16'($random(seed));
            wr_masks[i]  = 2'($random(seed));
            rd_expect[i] = {wr_masks[i][1] ? old_word[15:8] : wr_words[i][15:8],
                            wr_masks[i][0] ? old_word[7:0] : wr_words[i][7:0]};
        end
        start_burst(1'b1, base);
        finish_burst(1'b1);

        start_burst(1'b0, base);
        finish_burst(1'b0);

        repeat (CPH_CYCLES + 4) @(posedge sys_clk);
        check_eq("sequences seen by the model", u_model.seq_cnt, 7);
        check_eq("first write command", u_model.cmd_log[4], 8'ha0);
        check_eq("second write command", u_model.cmd_log[5], 8'ha0);
        check_eq("read command", u_model.cmd_log[6], 8'h20);
        check_eq("done pulses", done_cnt, requests);

        $display("errors: %0d, requests: %0d, done pulses: %0d", errors, requests, done_cnt);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
